/* include/periph_consts.svh */
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Register bus
`define PERIPH_ADDR_W    12
`define PERIPH_DATA_W    32
`define PERIPH_OFFS_W    8
`define PERIPH_ERR_RDATA 32'hDEADBEEF

// Peripheral select, address bits [11:8]
`define PERIPH_SEL_IRQ   4'd0
`define PERIPH_SEL_UART  4'd1

// Interrupt controller
`define IRQ_NUM_SOURCES  8
`define IRQ_NUM_TARGETS  2
`define IRQ_PRIO_W       3
`define IRQ_PRIO_OFFS    8'h00
`define IRQ_PENDING_OFFS 8'h40
`define IRQ_ENABLE_OFFS  8'h80
`define IRQ_THRESH_OFFS  8'hC0
`define IRQ_CLAIM_OFFS   8'hE0

// UART
`define UART_DATA_OFFS   8'h00
`define UART_STATUS_OFFS 8'h04
`define UART_DIV_OFFS    8'h08
`define UART_IE_OFFS     8'h0C
`define UART_DIV_W       16
`define UART_DIV_RESET   16'd16

`endif

/* src/periph_pkg.sv */
`include "periph_consts.svh"

package periph_pkg;

    // ------------------------------
    // Register bus field types
    // ------------------------------
    typedef logic [`PERIPH_ADDR_W-1:0] reg_addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] reg_data_t;

    // Offset inside one peripheral page
    typedef logic [`PERIPH_OFFS_W-1:0] reg_offs_t;

    // ------------------------------
    // Request and response
    // ------------------------------

    // From the single master, valid is a one-cycle strobe
    typedef struct packed {
        logic      valid;
        logic      write;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    // Always answered one cycle after the request
    typedef struct packed {
        logic      valid;
        reg_data_t rdata;
        logic      error;
    } reg_rsp_t;

endpackage

/* src/reg_decoder.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module reg_decoder import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  reg_req_t req_i,
    input  reg_rsp_t irq_rsp_i,
    input  reg_rsp_t uart_rsp_i,
    output reg_req_t irq_req_o,
    output reg_req_t uart_req_o,
    output reg_rsp_t rsp_o
);

    typedef enum logic [1:0] {
        sel_irq,
        sel_uart,
        sel_none
    } sel_e;

    logic [`PERIPH_ADDR_W-`PERIPH_OFFS_W-1:0] page;
    sel_e                                     sel_d;
    sel_e                                     sel_q;
    reg_req_t                                 fwd_req;
    logic                                     err_valid_q;

    // ------------------------------
    // Request routing
    // ------------------------------
    assign page = req_i.addr[`PERIPH_ADDR_W-1:`PERIPH_OFFS_W];

    always_comb begin
        case (page)
            `PERIPH_SEL_IRQ:  sel_d = sel_irq;
            `PERIPH_SEL_UART: sel_d = sel_uart;
            default:          sel_d = sel_none;
        endcase
    end

    // Peers only see the offset inside their page
    always_comb begin
        fwd_req      = req_i;
        fwd_req.addr = reg_addr_t'(req_i.addr[`PERIPH_OFFS_W-1:0]);

        irq_req_o        = fwd_req;
        irq_req_o.valid  = req_i.valid && sel_d == sel_irq;
        uart_req_o       = fwd_req;
        uart_req_o.valid = req_i.valid && sel_d == sel_uart;
    end

    // ------------------------------
    // Response selection
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q       <= sel_none;
            err_valid_q <= 1'b0;
        end else begin
            err_valid_q <= req_i.valid && sel_d == sel_none;
            // Held until the next request, peers pulse valid for one cycle
            if (req_i.valid) begin
                sel_q <= sel_d;
            end
        end
    end

    always_comb begin
        case (sel_q)
            sel_irq:  rsp_o = irq_rsp_i;
            sel_uart: rsp_o = uart_rsp_i;
            default: begin
                rsp_o.valid = err_valid_q;
                rsp_o.rdata = `PERIPH_ERR_RDATA;
                rsp_o.error = 1'b1;
            end
        endcase
    end

endmodule

/* src/irq_ctrl.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module irq_ctrl import periph_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  reg_req_t                    req_i,
    input  logic [`IRQ_NUM_SOURCES-1:0] irq_src_i,
    output reg_rsp_t                    rsp_o,
    output logic [`IRQ_NUM_TARGETS-1:0] irq_o
);

    // IDs start at 1, 0 means nothing to claim
    localparam int id_w = $clog2(`IRQ_NUM_SOURCES + 1);

    logic [`IRQ_NUM_SOURCES-1:0][`IRQ_PRIO_W-1:0]     prio_q;
    logic [`IRQ_NUM_TARGETS-1:0][`IRQ_NUM_SOURCES-1:0] en_q;
    logic [`IRQ_NUM_TARGETS-1:0][`IRQ_PRIO_W-1:0]     thresh_q;
    logic [`IRQ_NUM_SOURCES-1:0]                      pending_q;
    logic [`IRQ_NUM_SOURCES-1:0]                      in_service_q;

    logic [`IRQ_NUM_TARGETS-1:0][id_w-1:0]        claim_id;
    logic [`IRQ_NUM_TARGETS-1:0][`IRQ_PRIO_W-1:0] best_prio;

    reg_offs_t                   offs;
    reg_data_t                   acc_rdata;
    logic                        acc_err;
    logic [`IRQ_NUM_SOURCES-1:0] claim_clr;
    logic [`IRQ_NUM_SOURCES-1:0] complete_clr;

    logic      rsp_valid_q;
    reg_data_t rsp_rdata_q;
    logic      rsp_err_q;

    // ------------------------------
    // Winner per target
    // ------------------------------
    always_comb begin
        claim_id  = '0;
        best_prio = '0;
        for (int t = 0; t < `IRQ_NUM_TARGETS; t++) begin
            // Strict compare, so ties go to the lowest index and prio 0 never wins
            for (int i = 0; i < `IRQ_NUM_SOURCES; i++) begin
                if (pending_q[i] && en_q[t][i] && prio_q[i] > best_prio[t]) begin
                    best_prio[t] = prio_q[i];
                    claim_id[t]  = id_w'(i + 1);
                end
            end
        end
    end

    always_comb begin
        for (int t = 0; t < `IRQ_NUM_TARGETS; t++) begin
            irq_o[t] = best_prio[t] > thresh_q[t];
        end
    end

    // ------------------------------
    // Register access
    // ------------------------------
    assign offs = req_i.addr[`PERIPH_OFFS_W-1:0];

    always_comb begin
        acc_rdata    = '0;
        acc_err      = 1'b0;
        claim_clr    = '0;
        complete_clr = '0;
        for (int i = 0; i < `IRQ_NUM_SOURCES; i++) begin
            if (offs == reg_offs_t'(`IRQ_PRIO_OFFS + 4 * i)) begin
                acc_rdata = reg_data_t'(prio_q[i]);
            end
        end
        if (offs == `IRQ_PENDING_OFFS) begin
            acc_rdata = reg_data_t'(pending_q);
            acc_err   = req_i.write;
        end
        for (int t = 0; t < `IRQ_NUM_TARGETS; t++) begin
            if (offs == reg_offs_t'(`IRQ_ENABLE_OFFS + 4 * t)) begin
                acc_rdata = reg_data_t'(en_q[t]);
            end
            if (offs == reg_offs_t'(`IRQ_THRESH_OFFS + 4 * t)) begin
                acc_rdata = reg_data_t'(thresh_q[t]);
            end
            if (offs == reg_offs_t'(`IRQ_CLAIM_OFFS + 4 * t)) begin
                acc_rdata = reg_data_t'(claim_id[t]);
                for (int i = 0; i < `IRQ_NUM_SOURCES; i++) begin
                    // Claim on read, complete on write of the same ID
                    if (req_i.valid && !req_i.write && claim_id[t] == id_w'(i + 1)) begin
                        claim_clr[i] = 1'b1;
                    end
                    if (req_i.valid && req_i.write && req_i.wdata == reg_data_t'(i + 1)) begin
                        complete_clr[i] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q       <= '0;
            en_q         <= '0;
            thresh_q     <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
            rsp_valid_q  <= 1'b0;
        end else begin
            rsp_valid_q  <= req_i.valid;
            // Level sources re-pend after completion while still high
            pending_q    <= (pending_q | (irq_src_i & ~in_service_q)) & ~claim_clr;
            in_service_q <= (in_service_q | claim_clr) & ~complete_clr;
            if (req_i.valid && req_i.write) begin
                for (int i = 0; i < `IRQ_NUM_SOURCES; i++) begin
                    if (offs == reg_offs_t'(`IRQ_PRIO_OFFS + 4 * i)) begin
                        prio_q[i] <= req_i.wdata[`IRQ_PRIO_W-1:0];
                    end
                end
                for (int t = 0; t < `IRQ_NUM_TARGETS; t++) begin
                    if (offs == reg_offs_t'(`IRQ_ENABLE_OFFS + 4 * t)) begin
                        en_q[t] <= req_i.wdata[`IRQ_NUM_SOURCES-1:0];
                    end
                    if (offs == reg_offs_t'(`IRQ_THRESH_OFFS + 4 * t)) begin
                        thresh_q[t] <= req_i.wdata[`IRQ_PRIO_W-1:0];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_rdata_q <= acc_rdata;
        rsp_err_q   <= acc_err;
    end

    assign rsp_o = '{valid: rsp_valid_q, rdata: rsp_rdata_q, error: rsp_err_q};

endmodule

/* src/uart_lite.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module uart_lite import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  reg_req_t req_i,
    input  logic     rx_i,
    output reg_rsp_t rsp_o,
    output logic     tx_o,
    output logic     irq_o
);

    reg_offs_t offs;
    logic      wr;
    logic      rd;
    reg_data_t acc_rdata;
    logic      acc_err;
    logic      tx_start;
    logic      div_we;
    logic      ie_we;
    logic      data_rd;
    logic      status_rd;

    logic [`UART_DIV_W-1:0] div_q;
    logic                   ie_q;

    logic                   tx_busy_q;
    logic                   tx_q;
    logic [7:0]             tx_shift_q;
    logic [3:0]             tx_bits_q;
    logic [`UART_DIV_W-1:0] tx_cnt_q;

    logic [1:0]             rx_sync_q;
    logic                   rx_in;
    logic                   rx_busy_q;
    logic [3:0]             rx_bits_q;
    logic [`UART_DIV_W-1:0] rx_cnt_q;
    logic                   rx_sample;
    logic                   rx_done;
    logic [7:0]             rx_shift_q;
    logic [7:0]             rx_data_q;
    logic                   rx_valid_q;
    logic                   overrun_q;

    logic      rsp_valid_q;
    reg_data_t rsp_rdata_q;
    logic      rsp_err_q;

    // ------------------------------
    // Register access
    // ------------------------------
    assign offs = req_i.addr[`PERIPH_OFFS_W-1:0];
    assign wr   = req_i.valid && req_i.write;
    assign rd   = req_i.valid && !req_i.write;

    always_comb begin
        acc_rdata = '0;
        acc_err   = 1'b0;
        case (offs)
            `UART_DATA_OFFS: begin
                acc_rdata = reg_data_t'(rx_data_q);
                acc_err   = req_i.write && tx_busy_q;
            end
            `UART_STATUS_OFFS: begin
                acc_rdata = reg_data_t'({overrun_q, rx_valid_q, tx_busy_q});
                acc_err   = req_i.write;
            end
            `UART_DIV_OFFS: begin
                acc_rdata = reg_data_t'(div_q);
                // Zero divisor would stall both shifters
                acc_err   = req_i.write && req_i.wdata[`UART_DIV_W-1:0] == '0;
            end
            `UART_IE_OFFS: acc_rdata = reg_data_t'(ie_q);
            default: ;
        endcase
    end

    assign tx_start  = wr && offs == `UART_DATA_OFFS && !acc_err;
    assign div_we    = wr && offs == `UART_DIV_OFFS && !acc_err;
    assign ie_we     = wr && offs == `UART_IE_OFFS;
    assign data_rd   = rd && offs == `UART_DATA_OFFS;
    assign status_rd = rd && offs == `UART_STATUS_OFFS;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_q       <= `UART_DIV_RESET;
            ie_q        <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.valid;
            if (div_we) begin
                div_q <= req_i.wdata[`UART_DIV_W-1:0];
            end
            if (ie_we) begin
                ie_q <= req_i.wdata[0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_rdata_q <= acc_rdata;
        rsp_err_q   <= acc_err;
    end

    assign rsp_o = '{valid: rsp_valid_q, rdata: rsp_rdata_q, error: rsp_err_q};

    // ------------------------------
    // Transmitter
    // ------------------------------
    // Start bit goes out on the write edge, then 9 more bit times
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_busy_q <= 1'b0;
            tx_q      <= 1'b1;
            tx_bits_q <= '0;
            tx_cnt_q  <= '0;
        end else if (tx_start) begin
            tx_busy_q <= 1'b1;
            tx_q      <= 1'b0;
            tx_bits_q <= 4'd9;
            tx_cnt_q  <= div_q - 1'b1;
        end else if (tx_busy_q) begin
            if (tx_cnt_q != '0) begin
                tx_cnt_q <= tx_cnt_q - 1'b1;
            end else if (tx_bits_q == '0) begin
                tx_busy_q <= 1'b0;
            end else begin
                tx_q      <= tx_shift_q[0];
                tx_bits_q <= tx_bits_q - 1'b1;
                tx_cnt_q  <= div_q - 1'b1;
            end
        end
    end

    // Data bits, then the stop bit shifted in from the top
    always_ff @(posedge clk_i) begin
        if (tx_start) begin
            tx_shift_q <= req_i.wdata[7:0];
        end else if (tx_busy_q && tx_cnt_q == '0) begin
            tx_shift_q <= {1'b1, tx_shift_q[7:1]};
        end
    end

    assign tx_o = tx_q;

    // ------------------------------
    // Receiver
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_sync_q <= 2'b11;
        end else begin
            rx_sync_q <= {rx_sync_q[0], rx_i};
        end
    end

    assign rx_in     = rx_sync_q[1];
    assign rx_sample = rx_busy_q && rx_cnt_q == '0;
    assign rx_done   = rx_sample && rx_bits_q == 4'd9 && rx_in;

    // Half a bit to the start bit centre, then whole bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_busy_q <= 1'b0;
            rx_bits_q <= '0;
            rx_cnt_q  <= '0;
        end else if (!rx_busy_q) begin
            if (!rx_in) begin
                rx_busy_q <= 1'b1;
                rx_bits_q <= '0;
                rx_cnt_q  <= div_q >> 1;
            end
        end else if (rx_cnt_q != '0) begin
            rx_cnt_q <= rx_cnt_q - 1'b1;
        end else begin
            rx_cnt_q  <= div_q - 1'b1;
            rx_bits_q <= rx_bits_q + 1'b1;
            // Start bit gone at its centre means a glitch
            if ((rx_bits_q == '0 && rx_in) || rx_bits_q == 4'd9) begin
                rx_busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_sample && rx_bits_q inside {[4'd1:4'd8]}) begin
            rx_shift_q <= {rx_in, rx_shift_q[7:1]};
        end
        if (rx_done) begin
            rx_data_q <= rx_shift_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_valid_q <= 1'b0;
            overrun_q  <= 1'b0;
        end else begin
            if (data_rd) begin
                rx_valid_q <= 1'b0;
            end
            if (status_rd) begin
                overrun_q <= 1'b0;
            end
            // New byte wins over a read in the same cycle
            if (rx_done) begin
                rx_valid_q <= 1'b1;
                if (rx_valid_q && !data_rd) begin
                    overrun_q <= 1'b1;
                end
            end
        end
    end

    assign irq_o = rx_valid_q & ie_q;

endmodule

/* src/periph_top.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_top import periph_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  reg_req_t                    req_i,
    input  logic [`IRQ_NUM_SOURCES-1:1] irq_src_i,
    input  logic                        uart_rx_i,
    output reg_rsp_t                    rsp_o,
    output logic [`IRQ_NUM_TARGETS-1:0] irq_o,
    output logic                        uart_tx_o
);

    reg_req_t irq_req;
    reg_rsp_t irq_rsp;
    reg_req_t uart_req;
    reg_rsp_t uart_rsp;
    logic     uart_irq;

    // UART RX takes source 0, pins the rest
    logic [`IRQ_NUM_SOURCES-1:0] irq_src;

    assign irq_src = {irq_src_i, uart_irq};

    reg_decoder i_reg_decoder (
        .clk_i      ( clk_i    ),
        .rst_n_i    ( rst_n_i  ),
        .req_i      ( req_i    ),
        .irq_rsp_i  ( irq_rsp  ),
        .uart_rsp_i ( uart_rsp ),
        .irq_req_o  ( irq_req  ),
        .uart_req_o ( uart_req ),
        .rsp_o      ( rsp_o    )
    );

    irq_ctrl i_irq_ctrl (
        .clk_i     ( clk_i   ),
        .rst_n_i   ( rst_n_i ),
        .req_i     ( irq_req ),
        .irq_src_i ( irq_src ),
        .rsp_o     ( irq_rsp ),
        .irq_o     ( irq_o   )
    );

    uart_lite i_uart_lite (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .req_i   ( uart_req  ),
        .rx_i    ( uart_rx_i ),
        .rsp_o   ( uart_rsp  ),
        .tx_o    ( uart_tx_o ),
        .irq_o   ( uart_irq  )
    );

endmodule

/* dv/periph_chk.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_chk import periph_pkg::*; (
    input logic                        clk_i,
    input logic                        rst_n_i,
    input reg_req_t                    req_i,
    input reg_rsp_t                    rsp_i,
    input logic [`IRQ_NUM_TARGETS-1:0] irq_i,
    input logic                        tx_i
);

    int timing_fails = 0;
    int rdata_fails  = 0;
    int irq_rst_fails = 0;
    int tx_rst_fails = 0;
    int fail_cnt;

    assign fail_cnt = timing_fails + rdata_fails + irq_rst_fails + tx_rst_fails;

    // ------------------------------
    // Register bus
    // ------------------------------
    rsp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_i.valid == $past(req_i.valid))
    else begin
        timing_fails++;
        $error("Response valid does not follow request valid by one cycle");
    end

    // Only unmapped reads give an error on a read
    err_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_i.valid && rsp_i.error && !$past(req_i.write) |-> rsp_i.rdata == `PERIPH_ERR_RDATA)
    else begin
        rdata_fails++;
        $error("Read error response without the error read data");
    end

    // ------------------------------
    // Outputs held in reset
    // ------------------------------
    rst_quiet: assert property (@(posedge clk_i) !rst_n_i |-> irq_i == '0 && !rsp_i.valid)
    else begin
        irq_rst_fails++;
        $error("Interrupt or response valid active during reset");
    end

    rst_tx_idle: assert property (@(posedge clk_i) !rst_n_i |-> tx_i)
    else begin
        tx_rst_fails++;
        $error("UART tx line not idle during reset");
    end

endmodule

bind periph_top periph_chk i_periph_chk (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .req_i   ( req_i     ),
    .rsp_i   ( rsp_o     ),
    .irq_i   ( irq_o     ),
    .tx_i    ( uart_tx_o )
);

/* dv/periph_tb.sv */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_tb import periph_pkg::*; ();

    localparam int half_period  = 20;
    localparam int reset_cycles = 16;
    localparam int frame_cycles = 10 * `UART_DIV_RESET;
    localparam int watchdog_cycles = reset_cycles + 4 * frame_cycles + 200;
    localparam int poll_limit   = 200;

    localparam logic [11:0] uart_data   = {`PERIPH_SEL_UART, `UART_DATA_OFFS};
    localparam logic [11:0] uart_status = {`PERIPH_SEL_UART, `UART_STATUS_OFFS};
    localparam logic [11:0] uart_div    = {`PERIPH_SEL_UART, `UART_DIV_OFFS};
    localparam logic [11:0] uart_ie     = {`PERIPH_SEL_UART, `UART_IE_OFFS};
    localparam logic [11:0] irq_pending = {`PERIPH_SEL_IRQ, `IRQ_PENDING_OFFS};
    localparam logic [11:0] irq_enable0 = {`PERIPH_SEL_IRQ, `IRQ_ENABLE_OFFS};
    localparam logic [11:0] irq_enable1 = irq_enable0 + 12'h4;
    localparam logic [11:0] irq_thresh0 = {`PERIPH_SEL_IRQ, `IRQ_THRESH_OFFS};
    localparam logic [11:0] irq_thresh1 = irq_thresh0 + 12'h4;
    localparam logic [11:0] irq_claim0  = {`PERIPH_SEL_IRQ, `IRQ_CLAIM_OFFS};

    logic                        clk;
    logic                        rst_n;
    reg_req_t                    req;
    reg_rsp_t                    rsp;
    logic [`IRQ_NUM_SOURCES-1:1] irq_src;
    logic [`IRQ_NUM_TARGETS-1:0] irq;
    logic                        uart_loop;
    logic [31:0]                 lfsr;
    int                          check_errors = 0;
    int                          fault_errors = 0;

    // TX wired straight back to RX
    periph_top i_periph_top (
        .clk_i     ( clk       ),
        .rst_n_i   ( rst_n     ),
        .req_i     ( req       ),
        .irq_src_i ( irq_src   ),
        .uart_rx_i ( uart_loop ),
        .rsp_o     ( rsp       ),
        .irq_o     ( irq       ),
        .uart_tx_o ( uart_loop )
    );

    initial clk = 1'b0;
    always #(half_period) clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // Taps 32 22 2 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [11:0] prio_addr(input int i);
        return {`PERIPH_SEL_IRQ, 8'(`IRQ_PRIO_OFFS + 4 * i)};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else begin
            check_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic bus_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int lat;
        bit seen;
        seen = 1'b0;
        @(posedge clk);
        req <= '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
        @(posedge clk);
        req.valid <= 1'b0;
        for (lat = 1; lat <= 4; lat++) begin
            @(negedge clk);
            if (rsp.valid) begin
                seen = 1'b1;
                break;
            end
        end
        rdata = rsp.rdata;
        err   = rsp.error;
        if (!seen) begin
            fault_errors++;
            $display("No response to the bus access at address %h", addr);
        end else begin
            compare_value("response latency", 32'd1, 32'(lat));
        end
    endtask

    task automatic read_expect(input string name, input logic [11:0] addr,
                               input logic [31:0] exp, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b0, addr, 32'd0, rdata, err);
        compare_value({name, " error"}, 32'(exp_err), 32'(err));
        compare_value(name, exp, rdata);
    endtask

    task automatic write_expect(input string name, input logic [11:0] addr,
                                input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b1, addr, data, rdata, err);
        compare_value({name, " error"}, 32'(exp_err), 32'(err));
    endtask

    task automatic poll_status(input string name, input logic [31:0] mask,
                               input logic [31:0] value);
        logic [31:0] rdata;
        logic        err;
        int          n;
        for (n = 0; n < poll_limit; n++) begin
            bus_access(1'b0, uart_status, 32'd0, rdata, err);
            if ((rdata & mask) == value) begin
                break;
            end
        end
        if (n == poll_limit) begin
            fault_errors++;
            $display("Gave up waiting for UART status: %s", name);
        end
    endtask

    task automatic wait_irq(input string name, input int t);
        int n;
        for (n = 0; n < 2 * frame_cycles; n++) begin
            @(negedge clk);
            if (irq[t]) begin
                break;
            end
        end
        if (n == 2 * frame_cycles) begin
            fault_errors++;
            $display("Interrupt never rose: %s", name);
        end
    endtask

    task automatic drive_src(input int idx, input logic val);
        @(posedge clk);
        irq_src[idx] <= val;
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic reset_state();
        @(negedge clk);
        compare_value("irq after reset", 32'd0, 32'(irq));
        compare_value("uart tx after reset", 32'd1, 32'(uart_loop));
        read_expect("uart divisor after reset", uart_div, 32'd16, 1'b0);
    endtask

    task automatic unmapped_access();
        read_expect("unmapped read 0x200", 12'h200, `PERIPH_ERR_RDATA, 1'b1);
        write_expect("unmapped write 0x3f0", 12'h3f0, 32'h1234_5678, 1'b1);
        read_expect("unmapped read 0xf04", 12'hf04, `PERIPH_ERR_RDATA, 1'b1);
    endtask

    task automatic uart_loopback();
        logic [7:0]  b;
        logic [31:0] rdata;
        logic        err;
        for (int k = 0; k < 3; k++) begin
            poll_status("tx idle", 32'h1, 32'h0);
            random_byte(b);
            write_expect("uart tx write", uart_data, 32'(b), 1'b0);
            write_expect("uart write while busy", uart_data, 32'h0000_00a5, 1'b1);
            poll_status("rx valid", 32'h2, 32'h2);
            read_expect("uart rx byte", uart_data, 32'(b), 1'b0);
            // rx_valid and overrun both clear
            bus_access(1'b0, uart_status, 32'd0, rdata, err);
            compare_value("uart status after rx read", 32'h0, rdata & 32'h6);
        end
    endtask

    task automatic uart_irq_route();
        logic [7:0] b;
        write_expect("uart irq enable", uart_ie, 32'h1, 1'b0);
        write_expect("source 0 priority", prio_addr(0), 32'd2, 1'b0);
        write_expect("target 0 enable", irq_enable0, 32'h01, 1'b0);
        write_expect("target 0 threshold", irq_thresh0, 32'd1, 1'b0);
        poll_status("tx idle", 32'h1, 32'h0);
        random_byte(b);
        write_expect("uart tx write", uart_data, 32'(b), 1'b0);
        wait_irq("uart rx on target 0", 0);
        compare_value("target 1 irq with uart source", 32'd0, 32'(irq[1]));
        read_expect("claim uart source", irq_claim0, 32'd1, 1'b0);
        read_expect("uart rx byte", uart_data, 32'(b), 1'b0);
        write_expect("complete uart source", irq_claim0, 32'd1, 1'b0);
        compare_value("irq after uart completion", 32'd0, 32'(irq));
    endtask

    task automatic prio_threshold();
        write_expect("source 3 priority", prio_addr(3), 32'd4, 1'b0);
        write_expect("source 5 priority", prio_addr(5), 32'd6, 1'b0);
        write_expect("target 0 enable", irq_enable0, 32'h28, 1'b0);
        write_expect("target 1 enable", irq_enable1, 32'h28, 1'b0);
        write_expect("target 0 threshold", irq_thresh0, 32'd0, 1'b0);
        write_expect("target 1 threshold", irq_thresh1, 32'd6, 1'b0);
        drive_src(3, 1'b1);
        drive_src(5, 1'b1);
        wait_irq("sources 3 and 5 on target 0", 0);
        compare_value("target 1 irq at threshold 6", 32'd0, 32'(irq[1]));
        read_expect("pending sources 3 and 5", irq_pending, 32'h28, 1'b0);
        read_expect("claim highest priority", irq_claim0, 32'd6, 1'b0);
        read_expect("pending after first claim", irq_pending, 32'h08, 1'b0);
        // Line drops so the completed source stays idle
        drive_src(5, 1'b0);
        write_expect("complete source 5", irq_claim0, 32'd6, 1'b0);
        read_expect("claim next priority", irq_claim0, 32'd4, 1'b0);
        read_expect("pending with both claimed", irq_pending, 32'h00, 1'b0);
        compare_value("irq with nothing pending", 32'd0, 32'(irq));
        drive_src(3, 1'b0);
        write_expect("complete source 3", irq_claim0, 32'd4, 1'b0);
        read_expect("claim with nothing pending", irq_claim0, 32'd0, 1'b0);
        write_expect("pending write refused", irq_pending, 32'hff, 1'b1);
        compare_value("target 1 irq at end", 32'd0, 32'(irq[1]));
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        rst_n   = 1'b1;
        req     = '0;
        irq_src = '0;
        lfsr    = 32'hd644b3ac;
        // Falling edge before the first clock starts the asynchronous reset
        #1 rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        unmapped_access();
        uart_loopback();
        uart_irq_route();
        prio_threshold();
        $display("Errors: %0d check, %0d protocol, %0d assertion",
                 check_errors, fault_errors, i_periph_top.i_periph_chk.fail_cnt);
        if (check_errors == 0 && fault_errors == 0 && i_periph_top.i_periph_chk.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* build.f */
+incdir+include
src/periph_pkg.sv
src/reg_decoder.sv
src/irq_ctrl.sv
src/uart_lite.sv
src/periph_top.sv
dv/periph_chk.sv
dv/periph_tb.sv

/* Makefile */
# Verilator build and run for the peripheral subsystem testbench

TOP = periph_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "=== PASS ===" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
